/* ifetch_top.f */
ifetch_pkg.sv
fetch_pc_gen.sv
icache_array.sv
icache_ctrl.sv
instr_predecode.sv
ifetch_top.sv
ifetch_sva.sv
ifetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the ifetch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ifetch_tb \
   -f ifetch_top.f -o ifetch_sim > build.log 2>&1 \
   && ./obj_dir/ifetch_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

/* ifetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ifetch_tb
   import ifetch_pkg::*;
;

   localparam int    LINE_COUNT = 16;
   localparam addr_t RESET_PC   = '0;
   localparam int    N_INSTR    = 100;
   localparam int    MAX_CYCLES = 40 * N_INSTR;
   localparam int    PROG_WORDS = 256;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic        stall_i;
   logic        mem_busy_i;
   logic        mem_ready_i;
   line_t       mem_line_i;
   logic        mem_req_o;
   addr_t       mem_addr_o;
   logic        out_valid_o;
   predecoded_t out_pkt_o;

   word_t  prog [PROG_WORDS];
   integer seed = 40683;
   int     n_checked = 0;
   int     value_errors = 0;
   int     req_errors = 0;
   int     cycles = 0;
   logic   timed_out = 1'b0;
   logic   stall_last = 1'b0;
   int     exp_req [addr_t];
   int     seen_req [addr_t];
   addr_t  model_line [LINE_COUNT];
   logic   model_valid [LINE_COUNT];
   logic   mem_pending = 1'b0;
   int     delay_cnt = 0;
   addr_t  pend_addr = '0;

   ifetch_top #(
      .LINE_COUNT (LINE_COUNT),
      .RESET_PC   (RESET_PC)
   ) ifetch_top_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .stall_i     (stall_i),
      .mem_busy_i  (mem_busy_i),
      .mem_ready_i (mem_ready_i),
      .mem_line_i  (mem_line_i),
      .mem_req_o   (mem_req_o),
      .mem_addr_o  (mem_addr_o),
      .out_valid_o (out_valid_o),
      .out_pkt_o   (out_pkt_o)
   );

   always #50 clk_i = ~clk_i;

   function automatic word_t jal_word(input int off);
      logic [20:0] imm;
      imm = off[20:0];
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
   endfunction

   function automatic word_t image_word(input addr_t a);
      return prog[a[9:2]];
   endfunction

   function automatic instr_class_t class_of(input word_t w);
      case (w[6:0])
         7'b0010011, 7'b0110011: return CLS_ALU;
         7'b0000011:             return CLS_LOAD;
         7'b0100011:             return CLS_STORE;
         7'b1100011:             return CLS_BRANCH;
         7'b1101111:             return CLS_JAL;
         7'b1100111:             return CLS_JALR;
         7'b1110011:             return CLS_SYSTEM;
         default:                return CLS_OTHER;
      endcase
   endfunction

   // walks the image from the reset pc to the n-th instruction.
   function automatic predecoded_t ref_instr(input int n);
      addr_t       pc;
      word_t       w;
      addr_t       imm;
      predecoded_t p;
      pc = RESET_PC;
      for (int i = 0; i < n; i++) begin
         w = image_word(pc);
         if (w[6:0] == 7'b1101111) begin
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            pc  = pc + imm;
         end else begin
            pc = pc + 32'd4;
         end
      end
      w       = image_word(pc);
      p.pc    = pc;
      p.instr = w;
      p.cls   = class_of(w);
      return p;
   endfunction

   task automatic build_image();
      logic [6:0] ops [6];
      word_t      r;
      ops = '{7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011, 7'b1110011, 7'b0001011};
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = {i[22:0] ^ 23'h5a5a5, 2'b00, 7'b0001011};
      end
      for (int i = 0; i < 68; i++) begin
         if (i < 15 || (i >= 64 && i < 67)) begin
            r       = $random(seed);
            prog[i] = {r[31:7], ops[{$random(seed)} % 6]};
         end
      end
      prog[15] = jal_word(32'h100 - 32'h3c);   // lines 0..3, then the conflicting line.
      prog[67] = jal_word(-32'h10c);           // back to 0x000, evicts 0x100.
   endtask

   task automatic compare_requests();
      int got;
      foreach (exp_req[a]) begin
         got = seen_req.exists(a) ? seen_req[a] : 0;
         if (got != exp_req[a]) begin
            req_errors++;
            $display("[ERROR] %0t mem_req_o line %h: expected %0d got %0d",
                     $time, a, exp_req[a], got);
         end
      end
      foreach (seen_req[a]) begin
         if (!exp_req.exists(a)) begin
            req_errors++;
            $display("[ERROR] %0t mem_req_o line %h: expected 0 got %0d",
                     $time, a, seen_req[a]);
         end
      end
   endtask

   // memory model, stall and busy windows.
   always @(negedge clk_i) begin
      if (rst_i) begin
         mem_ready_i = 1'b0;
         stall_i     = ({$random(seed)} % 5) == 0;
         if (mem_pending) begin
            delay_cnt--;
            if (delay_cnt == 0) begin
               mem_ready_i = 1'b1;
               mem_line_i  = {image_word(pend_addr + 32'd12), image_word(pend_addr + 32'd8),
                              image_word(pend_addr + 32'd4), image_word(pend_addr)};
               mem_pending = 1'b0;
            end
         end else begin
            mem_busy_i = ({$random(seed)} % 4) == 0;
            if (mem_req_o && !mem_busy_i) begin
               mem_pending = 1'b1;   // taken at the next rising edge.
               pend_addr   = mem_addr_o;
               delay_cnt   = 1 + ({$random(seed)} % 6);
               if (n_checked < N_INSTR) begin
                  seen_req[mem_addr_o] = seen_req.exists(mem_addr_o) ?
                                         seen_req[mem_addr_o] + 1 : 1;
               end
            end
         end
      end
   end

   // compares each output pulse with the reference.
   always @(posedge clk_i) begin
      predecoded_t exp_pkt;
      int          idx;
      addr_t       line;
      if (rst_i) begin
         cycles++;
         if (cycles > MAX_CYCLES) timed_out = 1'b1;
         if (out_valid_o && stall_last) begin
            value_errors++;
            $display("out_valid_o rose at %0t for a cycle in which stall_i was high", $time);
         end
         if (out_valid_o && n_checked < N_INSTR) begin
            exp_pkt = ref_instr(n_checked);
            if (out_pkt_o.pc != exp_pkt.pc) begin
               value_errors++;
               $display("[ERROR] %0t out_pkt_o.pc expected %h got %h",
                        $time, exp_pkt.pc, out_pkt_o.pc);
            end
            if (out_pkt_o.instr != exp_pkt.instr) begin
               value_errors++;
               $display("[ERROR] %0t out_pkt_o.instr expected %h got %h",
                        $time, exp_pkt.instr, out_pkt_o.instr);
            end
            if (out_pkt_o.cls != exp_pkt.cls) begin
               value_errors++;
               $display("[ERROR] %0t out_pkt_o.cls expected %0d got %0d",
                        $time, exp_pkt.cls, out_pkt_o.cls);
            end
            // direct-mapped model decides whether this fetch missed.
            line = {exp_pkt.pc[31:4], 4'b0000};
            idx  = int'((exp_pkt.pc >> 4) % LINE_COUNT);
            if (!model_valid[idx] || model_line[idx] != line) begin
               model_valid[idx] = 1'b1;
               model_line[idx]  = line;
               exp_req[line]    = exp_req.exists(line) ? exp_req[line] + 1 : 1;
            end
            n_checked++;
         end
         stall_last = stall_i;
      end
   end

   initial begin
      rst_i       = 1'b0;
      stall_i     = 1'b0;
      mem_busy_i  = 1'b0;
      mem_ready_i = 1'b0;
      mem_line_i  = '0;
      for (int i = 0; i < LINE_COUNT; i++) begin
         model_valid[i] = 1'b0;
         model_line[i]  = '0;
      end
      build_image();
      repeat (8) @(negedge clk_i);
      rst_i <= 1'b1;
      wait (n_checked == N_INSTR || timed_out);
      if (timed_out) begin
         $display("timeout: %0d of %0d instructions seen in %0d cycles",
                  n_checked, N_INSTR, MAX_CYCLES);
      end
      compare_requests();
      $display("value errors %0d, request errors %0d, timeouts %0d",
               value_errors, req_errors, timed_out ? 1 : 0);
      if (value_errors == 0 && req_errors == 0 && !timed_out) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* ifetch_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module ifetch_sva
   import ifetch_pkg::*;
(
   input wire logic       clk_i,
   input wire logic       rst_i,
   input wire logic       stall_i,
   input wire logic [1:0] state_i,
   input wire logic       mem_req_o,
   input wire addr_t      mem_addr_o,
   input wire logic       mem_ready_i,
   input wire logic       fetch_valid_o
);

   localparam logic [1:0] ST_FILL_DONE = 2'd3;

   // request held with a stable address until the line arrives.
   req_held: assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_req_o && !mem_ready_i |=> (mem_req_o || mem_ready_i) && $stable(mem_addr_o))
      else $error("mem_req_o dropped or mem_addr_o changed before mem_ready_i");

   no_deliver_during_req: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(fetch_valid_o && mem_req_o))
      else $error("fetch_valid_o and mem_req_o high together");

   no_deliver_stalled: assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i && state_i != ST_FILL_DONE |-> !fetch_valid_o)
      else $error("fetch_valid_o while stalled");

   line_aligned: assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_req_o |-> mem_addr_o[3:0] == 4'b0000)
      else $error("mem_addr_o not line aligned");

endmodule

bind icache_ctrl ifetch_sva ifetch_sva_inst (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .stall_i       (stall_i),
   .state_i       (state_q),
   .mem_req_o     (mem_req_o),
   .mem_addr_o    (mem_addr_o),
   .mem_ready_i   (mem_ready_i),
   .fetch_valid_o (fetch_valid_o)
);

`default_nettype wire

/* ifetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ifetch_top
   import ifetch_pkg::*;
#(
   parameter int    LINE_COUNT = 16,
   parameter addr_t RESET_PC   = '0
) (
   input  wire logic  clk_i,
   input  wire logic  rst_i,
   input  wire logic  stall_i,
   input  wire logic  mem_busy_i,
   input  wire logic  mem_ready_i,
   input  wire line_t mem_line_i,
   output logic       mem_req_o,
   output addr_t      mem_addr_o,
   output logic       out_valid_o,
   output predecoded_t out_pkt_o
);

   addr_t     pc;
   addr_t     lookup_addr;
   logic      hit;
   word_t     hit_word;
   logic      fill_we;
   mem_fill_t fill;
   logic      fetch_valid;
   fetched_t  fetch;
   logic      advance;
   logic      redirect;
   addr_t     target;

   fetch_pc_gen #(
      .RESET_PC (RESET_PC)
   ) fetch_pc_gen_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .advance_i  (advance),
      .redirect_i (redirect),
      .target_i   (target),
      .pc_o       (pc)
   );

   icache_ctrl icache_ctrl_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .stall_i       (stall_i),
      .pc_i          (pc),
      .lookup_addr_o (lookup_addr),
      .hit_i         (hit),
      .hit_word_i    (hit_word),
      .fill_we_o     (fill_we),
      .fill_o        (fill),
      .mem_busy_i    (mem_busy_i),
      .mem_ready_i   (mem_ready_i),
      .mem_line_i    (mem_line_i),
      .mem_req_o     (mem_req_o),
      .mem_addr_o    (mem_addr_o),
      .fetch_valid_o (fetch_valid),
      .fetch_o       (fetch)
   );

   icache_array #(
      .LINE_COUNT (LINE_COUNT)
   ) icache_array_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .lookup_addr_i (lookup_addr),
      .hit_o         (hit),
      .hit_word_o    (hit_word),
      .fill_we_i     (fill_we),
      .fill_i        (fill)
   );

   instr_predecode instr_predecode_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .fetch_valid_i (fetch_valid),
      .fetch_i       (fetch),
      .out_valid_o   (out_valid_o),
      .out_pkt_o     (out_pkt_o),
      .advance_o     (advance),
      .redirect_o    (redirect),
      .target_o      (target)
   );

endmodule

`default_nettype wire

/* instr_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_predecode
   import ifetch_pkg::*;
(
   input  wire logic     clk_i,
   input  wire logic     rst_i,
   input  wire logic     fetch_valid_i,
   input  wire fetched_t fetch_i,
   output logic          out_valid_o,
   output predecoded_t   out_pkt_o,
   output logic          advance_o,
   output logic          redirect_o,
   output addr_t         target_o
);

   localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
   localparam logic [6:0] OP_ALU_REG = 7'b0110011;
   localparam logic [6:0] OP_LOAD    = 7'b0000011;
   localparam logic [6:0] OP_STORE   = 7'b0100011;
   localparam logic [6:0] OP_BRANCH  = 7'b1100011;
   localparam logic [6:0] OP_JAL     = 7'b1101111;
   localparam logic [6:0] OP_JALR    = 7'b1100111;
   localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

   function automatic instr_class_t classify(input word_t instr);
      unique case (instr[6:0])
         OP_ALU_IMM, OP_ALU_REG: classify = CLS_ALU;
         OP_LOAD:                classify = CLS_LOAD;
         OP_STORE:               classify = CLS_STORE;
         OP_BRANCH:              classify = CLS_BRANCH;
         OP_JAL:                 classify = CLS_JAL;
         OP_JALR:                classify = CLS_JALR;
         OP_SYSTEM:              classify = CLS_SYSTEM;
         default:                classify = CLS_OTHER;
      endcase
   endfunction

   logic        out_valid_q;
   predecoded_t pkt_q;
   addr_t       j_imm;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= fetch_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_valid_i) begin
         pkt_q.pc    <= fetch_i.pc;
         pkt_q.instr <= fetch_i.instr;
         pkt_q.cls   <= classify(fetch_i.instr);
      end
   end

   // j-type immediate, sign extended.
   assign j_imm = {{12{pkt_q.instr[31]}}, pkt_q.instr[19:12], pkt_q.instr[20],
                   pkt_q.instr[30:21], 1'b0};

   assign out_valid_o = out_valid_q;
   assign out_pkt_o   = pkt_q;
   assign advance_o   = out_valid_q;   // pc moves on in the output cycle.
   assign redirect_o  = out_valid_q && (pkt_q.cls == CLS_JAL);
   assign target_o    = pkt_q.pc + j_imm;

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
   import ifetch_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      stall_i,
   input  wire addr_t     pc_i,
   output addr_t          lookup_addr_o,
   input  wire logic      hit_i,
   input  wire word_t     hit_word_i,
   output logic           fill_we_o,
   output mem_fill_t      fill_o,
   input  wire logic      mem_busy_i,
   input  wire logic      mem_ready_i,
   input  wire line_t     mem_line_i,
   output logic           mem_req_o,
   output addr_t          mem_addr_o,
   output logic           fetch_valid_o,
   output fetched_t       fetch_o
);

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      MEM_WAIT,
      FILL_DONE
   } ictrl_state_e;

   ictrl_state_e state_q;
   ictrl_state_e state_next;

   addr_t     line_addr_q;   // line being filled.
   word_sel_t word_sel_q;
   line_t     line_q;
   addr_t     pc_line_addr;
   word_t     fill_word;

   assign pc_line_addr = {pc_i[31:4], 4'b0000};
   assign fill_word    = line_q[word_sel_q*32 +: 32];

   // next state.
   always_comb begin
      state_next = state_q;
      unique case (state_q)
         IDLE: begin
            if (!stall_i) begin
               state_next = LOOKUP;
            end
         end
         LOOKUP: begin
            if (hit_i) begin
               if (!stall_i) begin
                  state_next = IDLE;
               end
            end else if (!mem_busy_i) begin
               // a miss already on the bus goes ahead even when stalled.
               state_next = MEM_WAIT;
            end
         end
         MEM_WAIT: begin
            if (mem_ready_i) begin
               state_next = FILL_DONE;
            end
         end
         FILL_DONE: begin
            if (!stall_i) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_next;
      end
   end

   // miss bookkeeping and the arriving line.
   always_ff @(posedge clk_i) begin
      if (state_q == LOOKUP && !hit_i && !mem_busy_i) begin
         line_addr_q <= pc_line_addr;
         word_sel_q  <= pc_i[3:2];
      end
      if (state_q == MEM_WAIT && mem_ready_i) begin
         line_q <= mem_line_i;
      end
   end

   assign lookup_addr_o = pc_i;

   // memory port.
   assign mem_req_o  = (state_q == LOOKUP && !hit_i) || (state_q == MEM_WAIT && !mem_ready_i);
   assign mem_addr_o = (state_q == MEM_WAIT) ? line_addr_q : pc_line_addr;

   // array write in the cycle the line arrives.
   assign fill_we_o   = (state_q == MEM_WAIT) && mem_ready_i;
   assign fill_o.addr = line_addr_q;
   assign fill_o.data = mem_line_i;

   // delivery to predecode.
   assign fetch_valid_o = !stall_i &&
                          ((state_q == LOOKUP && hit_i) || state_q == FILL_DONE);
   assign fetch_o.pc    = pc_i;   // pc holds still during a fill.
   assign fetch_o.instr = (state_q == FILL_DONE) ? fill_word : hit_word_i;

endmodule

`default_nettype wire

/* icache_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_array
   import ifetch_pkg::*;
#(
   parameter int LINE_COUNT = 16
) (
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire addr_t     lookup_addr_i,
   output logic           hit_o,
   output word_t          hit_word_o,
   input  wire logic      fill_we_i,
   input  wire mem_fill_t fill_i
);

   localparam int INDEX_W = $clog2(LINE_COUNT);
   localparam int TAG_W   = 32 - 4 - INDEX_W;

   // storage.
   line_t              line_mem [LINE_COUNT];
   logic [TAG_W-1:0]   tag_mem  [LINE_COUNT];
   logic [LINE_COUNT-1:0] valid_q;

   logic [INDEX_W-1:0] lk_idx;
   logic [TAG_W-1:0]   lk_tag;
   word_sel_t          lk_sel;
   logic [INDEX_W-1:0] fill_idx;
   logic [TAG_W-1:0]   fill_tag;
   line_t              lk_line;

   // split the addresses into tag, index and word select.
   assign lk_sel   = lookup_addr_i[3:2];
   assign lk_idx   = lookup_addr_i[4 +: INDEX_W];
   assign lk_tag   = lookup_addr_i[31 -: TAG_W];
   assign fill_idx = fill_i.addr[4 +: INDEX_W];
   assign fill_tag = fill_i.addr[31 -: TAG_W];

   // combinational lookup.
   assign lk_line    = line_mem[lk_idx];
   assign hit_o      = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
   assign hit_word_o = lk_line[lk_sel*32 +: 32];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_q <= '0;
      end else if (fill_we_i) begin
         valid_q[fill_idx] <= 1'b1;
      end
   end

   // a fill replaces whatever line sat at the index.
   always_ff @(posedge clk_i) begin
      if (fill_we_i) begin
         line_mem[fill_idx] <= fill_i.data;
         tag_mem[fill_idx]  <= fill_tag;
      end
   end

endmodule

`default_nettype wire

/* fetch_pc_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen
   import ifetch_pkg::*;
#(
   parameter addr_t RESET_PC = '0
) (
   input  wire logic  clk_i,
   input  wire logic  rst_i,
   input  wire logic  advance_i,
   input  wire logic  redirect_i,
   input  wire addr_t target_i,
   output addr_t      pc_o
);

   addr_t pc_q;
   addr_t pc_next;

   // next fetch address once the current one is consumed.
   always_comb begin
      pc_next = pc_q;
      if (advance_i) begin
         if (redirect_i) begin
            pc_next = target_i;   // jal target.
         end else begin
            pc_next = pc_q + 32'd4;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign pc_o = pc_q;

endmodule

`default_nettype wire

/* ifetch_pkg.sv */
`default_nettype none

package ifetch_pkg;

   // widths that carry a meaning.
   typedef logic [31:0]  addr_t;
   typedef logic [31:0]  word_t;
   typedef logic [127:0] line_t;
   typedef logic [1:0]   word_sel_t;   // address bits 3:2.
   typedef logic [2:0]   instr_class_t;

   // instruction classes.
   localparam instr_class_t CLS_ALU    = 3'd0;
   localparam instr_class_t CLS_LOAD   = 3'd1;
   localparam instr_class_t CLS_STORE  = 3'd2;
   localparam instr_class_t CLS_BRANCH = 3'd3;
   localparam instr_class_t CLS_JAL    = 3'd4;
   localparam instr_class_t CLS_JALR   = 3'd5;
   localparam instr_class_t CLS_SYSTEM = 3'd6;
   localparam instr_class_t CLS_OTHER  = 3'd7;

   // line write into the cache array.
   typedef struct packed {
      addr_t addr;   // line aligned.
      line_t data;
   } mem_fill_t;

   // word handed from the controller to predecode.
   typedef struct packed {
      addr_t pc;
      word_t instr;
   } fetched_t;

   // registered output of the fetch unit.
   typedef struct packed {
      addr_t        pc;
      word_t        instr;
      instr_class_t cls;
   } predecoded_t;

endpackage

`default_nettype wire
